//--- verilog/dac_sample_pkg.sv
package dac_sample_pkg;

	// one DAC sample word.
	localparam int sample_width = 16;

	// right shift applied to every lane, 0 to 15.
	localparam int scale_width = 4;

	// lanes per batch presented to the DAC.
	localparam int default_batch_samples = 4;

	typedef logic [sample_width-1:0] sample_t;

	// which generator feeds the output register.
	typedef enum logic [1:0] {
		mode_idle = 2'd0,
		mode_lfsr = 2'd1,
		mode_ramp = 2'd2
	} out_mode_t;

endpackage

//--- verilog/dac_cfg_pkg.sv
package dac_cfg_pkg;

	// register-map fresh bits.
	localparam int seed_valid_id = 0;
	localparam int ramp_valid_id = 1;
	localparam int halt_req_id = 2;
	localparam int spare_id = 3;
	localparam int fresh_width = spare_id + 1;

	localparam int payload_width =
		dac_sample_pkg::default_batch_samples * dac_sample_pkg::sample_width;

	// one-hot opcodes, same bit order as the register map commands.
	typedef enum logic [4:0] {
		op_scale = 5'd1,
		op_ramp = 5'd2,
		op_seed = 5'd4,
		op_halt = 5'd8,
		op_rst = 5'd16
	} cmd_op_t;

	// ramp setting sits in the low 32 bits.
	typedef struct packed {
		logic [payload_width-33:0] pad;
		dac_sample_pkg::sample_t step;
		dac_sample_pkg::sample_t start;
	} ramp_set_t;

	// same payload bits, read per opcode.
	typedef union packed {
		dac_sample_pkg::sample_t [dac_sample_pkg::default_batch_samples-1:0] seeds;
		ramp_set_t ramp;
	} cmd_payload_u;

	typedef struct packed {
		cmd_op_t op;
		logic [dac_sample_pkg::scale_width-1:0] scale;
		cmd_payload_u payload;
	} cmd_word_t;

endpackage

//--- verilog/cmd_link_if.sv
`timescale 1ns/100ps

interface cmd_link_if #(
	parameter int batch_samples = dac_sample_pkg::default_batch_samples
);
	import dac_cfg_pkg::*;

	cmd_word_t cmd;
	logic cmd_valid;
	logic cmd_rdy;
	logic cmd_done;

	// the command word is sized by the package lane count.
	if (batch_samples != dac_sample_pkg::default_batch_samples) begin : g_lane_check
		$error("cmd_link_if: batch_samples differs from the command payload size");
	end

	modport ctrl (
		output cmd,
		output cmd_valid,
		input cmd_rdy,
		input cmd_done
	);

	modport mixer (
		input cmd,
		input cmd_valid,
		output cmd_rdy,
		output cmd_done
	);

endinterface

//--- verilog/gen_link_if.sv
`timescale 1ns/100ps

interface gen_link_if #(
	parameter int batch_samples = dac_sample_pkg::default_batch_samples
);
	import dac_sample_pkg::*;
	import dac_cfg_pkg::*;

	// single-cycle strobes from the mixer.
	logic load;
	logic advance;
	cmd_payload_u load_data;

	// registered generator output.
	sample_t [batch_samples-1:0] batch;

	modport mixer (
		output load,
		output advance,
		output load_data,
		input batch
	);

	modport gen (
		input load,
		input advance,
		input load_data,
		output batch
	);

endinterface

//--- verilog/dac_config_ctrl.sv
`timescale 1ns/100ps

module dac_config_ctrl #(
	parameter int batch_samples = dac_sample_pkg::default_batch_samples
) (
	input logic ps_clk,
	input logic ps_rst,
	input logic [dac_cfg_pkg::fresh_width-1:0] fresh_bits,
	input dac_sample_pkg::sample_t [batch_samples-1:0] seed_data,
	input dac_sample_pkg::sample_t ramp_start,
	input dac_sample_pkg::sample_t ramp_step,
	input logic [dac_sample_pkg::scale_width-1:0] scale_factor,
	input logic halt,
	cmd_link_if.ctrl link
);
	import dac_sample_pkg::*;
	import dac_cfg_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_send,
		st_rst,
		st_halt
	} state_t;

	state_t state;
	logic seed_pend;
	logic ramp_pend;
	logic scale_pend;
	logic [scale_width-1:0] scale_q;
	logic halt_q;
	logic halt_evt;
	logic seed_req;
	logic ramp_req;
	logic scale_req;

	// halt is taken on its rising edge.
	assign halt_evt = (halt && !halt_q) || fresh_bits[halt_req_id];
	assign seed_req = seed_pend || fresh_bits[seed_valid_id];
	assign ramp_req = ramp_pend || fresh_bits[ramp_valid_id];
	assign scale_req = scale_pend || (scale_factor != scale_q);

	// payload filled according to opcode.
	function automatic cmd_word_t build_cmd(cmd_op_t op);
		cmd_word_t w;
		w.op = op;
		w.scale = scale_factor;
		w.payload = '0;
		if (op == op_seed) begin
			for (int i = 0; i < batch_samples; i++) begin
				w.payload.seeds[i] = seed_data[i];
			end
		end else if (op == op_ramp) begin
			w.payload.ramp.start = ramp_start;
			w.payload.ramp.step = ramp_step;
		end
		return w;
	endfunction

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			state <= st_rst;
			link.cmd_valid <= 1'b0;
			{seed_pend, ramp_pend, scale_pend} <= '0;
			scale_q <= '0;
			halt_q <= 1'b1;
		end else begin
			seed_pend <= seed_req;
			ramp_pend <= ramp_req;
			scale_pend <= scale_req;
			scale_q <= scale_factor;
			halt_q <= halt;
			if (halt_evt) begin
				state <= st_halt;
				link.cmd_valid <= 1'b0;
				{seed_pend, ramp_pend, scale_pend} <= '0;
			end else begin
				case (state)
					st_rst: begin
						link.cmd <= build_cmd(op_rst);
						link.cmd_valid <= 1'b1;
						state <= st_send;
					end
					st_halt: begin
						link.cmd <= build_cmd(op_halt);
						link.cmd_valid <= 1'b1;
						state <= st_send;
					end
					st_idle: begin
						// seed before ramp before scale.
						if (seed_req) begin
							link.cmd <= build_cmd(op_seed);
							link.cmd_valid <= 1'b1;
							seed_pend <= 1'b0;
							state <= st_send;
						end else if (ramp_req) begin
							link.cmd <= build_cmd(op_ramp);
							link.cmd_valid <= 1'b1;
							ramp_pend <= 1'b0;
							state <= st_send;
						end else if (scale_req) begin
							link.cmd <= build_cmd(op_scale);
							link.cmd_valid <= 1'b1;
							scale_pend <= 1'b0;
							state <= st_send;
						end
					end
					st_send: begin
						if (link.cmd_valid && link.cmd_rdy) begin
							link.cmd_valid <= 1'b0;
						end
						if (link.cmd_done) begin
							state <= st_idle;
						end
					end
					default: state <= st_idle;
				endcase
			end
		end
	end

endmodule

//--- verilog/lfsr_batch_gen.sv
`timescale 1ns/100ps

module lfsr_batch_gen #(
	parameter int batch_samples = dac_sample_pkg::default_batch_samples
) (
	input logic ps_clk,
	input logic ps_rst,
	gen_link_if.gen gen
);
	import dac_sample_pkg::*;

	localparam sample_t tap_mask = 16'hB400;

	sample_t [batch_samples-1:0] lanes;

	// galois step, taps 16 14 13 11.
	function automatic sample_t lfsr_step(sample_t s);
		if (s[0]) begin
			return (s >> 1) ^ tap_mask;
		end
		return s >> 1;
	endfunction

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			for (int i = 0; i < batch_samples; i++) begin
				lanes[i] <= sample_t'(1);
			end
		end else if (gen.load) begin
			for (int i = 0; i < batch_samples; i++) begin
				// all-zero state would lock up.
				if (gen.load_data.seeds[i] == '0) begin
					lanes[i] <= sample_t'(1);
				end else begin
					lanes[i] <= gen.load_data.seeds[i];
				end
			end
		end else if (gen.advance) begin
			for (int i = 0; i < batch_samples; i++) begin
				lanes[i] <= lfsr_step(lanes[i]);
			end
		end
	end

	assign gen.batch = lanes;

endmodule

//--- verilog/ramp_batch_gen.sv
`timescale 1ns/100ps

module ramp_batch_gen #(
	parameter int batch_samples = dac_sample_pkg::default_batch_samples
) (
	input logic ps_clk,
	input logic ps_rst,
	gen_link_if.gen gen
);
	import dac_sample_pkg::*;

	sample_t step;
	sample_t stride;
	sample_t [batch_samples-1:0] lanes;

	// base moves by one whole batch per advance.
	assign stride = sample_t'(batch_samples) * step;

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			step <= '0;
			lanes <= '0;
		end else if (gen.load) begin
			step <= gen.load_data.ramp.step;
			for (int i = 0; i < batch_samples; i++) begin
				lanes[i] <= gen.load_data.ramp.start + sample_t'(i) * gen.load_data.ramp.step;
			end
		end else if (gen.advance) begin
			for (int i = 0; i < batch_samples; i++) begin
				lanes[i] <= lanes[i] + stride;
			end
		end
	end

	// lane 0 is the base.
	assign gen.batch = lanes;

endmodule

//--- verilog/batch_mixer.sv
`timescale 1ns/100ps

module batch_mixer #(
	parameter int batch_samples = dac_sample_pkg::default_batch_samples
) (
	input logic ps_clk,
	input logic ps_rst,
	cmd_link_if.mixer link,
	gen_link_if.mixer lfsr,
	gen_link_if.mixer ramp,
	input logic dac_rdy,
	output dac_sample_pkg::sample_t [batch_samples-1:0] dac_batch,
	output logic dac_batch_valid
);
	import dac_sample_pkg::*;
	import dac_cfg_pkg::*;

	out_mode_t mode;
	logic [scale_width-1:0] scale;
	cmd_payload_u payload_q;
	logic gen_fresh;
	logic take;
	logic cmd_take;
	logic capture;
	sample_t [batch_samples-1:0] sel_batch;

	assign take = dac_batch_valid && dac_rdy;
	assign cmd_take = link.cmd_valid && link.cmd_rdy;
	// gen_fresh marks a generator batch not yet copied to the output.
	assign capture = (mode != mode_idle) && gen_fresh && (!dac_batch_valid || take);
	assign sel_batch = (mode == mode_ramp) ? ramp.batch : lfsr.batch;
	assign lfsr.load_data = payload_q;
	assign ramp.load_data = payload_q;

	always_ff @(posedge ps_clk) begin
		if (capture) begin
			for (int i = 0; i < batch_samples; i++) begin
				dac_batch[i] <= sel_batch[i] >> scale;
			end
		end
		if (cmd_take) begin
			payload_q <= link.cmd.payload;
		end
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			mode <= mode_idle;
			scale <= '0;
			dac_batch_valid <= 1'b0;
			gen_fresh <= 1'b0;
			{lfsr.load, lfsr.advance, ramp.load, ramp.advance} <= '0;
			link.cmd_rdy <= 1'b1;
			link.cmd_done <= 1'b0;
		end else begin
			{lfsr.load, lfsr.advance, ramp.load, ramp.advance} <= '0;
			link.cmd_rdy <= 1'b1;
			link.cmd_done <= 1'b0;
			// generator output turns over on the strobe edge.
			if (lfsr.load || lfsr.advance || ramp.load || ramp.advance) begin
				gen_fresh <= 1'b1;
			end
			if (take) begin
				dac_batch_valid <= 1'b0;
				lfsr.advance <= (mode == mode_lfsr);
				ramp.advance <= (mode == mode_ramp);
			end
			if (capture) begin
				dac_batch_valid <= 1'b1;
				gen_fresh <= 1'b0;
			end
			if (cmd_take) begin
				link.cmd_rdy <= 1'b0;
				link.cmd_done <= 1'b1;
				dac_batch_valid <= 1'b0;
				case (link.cmd.op)
					op_rst, op_halt: mode <= mode_idle;
					op_seed: begin
						mode <= mode_lfsr;
						lfsr.load <= 1'b1;
						gen_fresh <= 1'b0;
					end
					op_ramp: begin
						mode <= mode_ramp;
						ramp.load <= 1'b1;
						gen_fresh <= 1'b0;
					end
					op_scale: begin
						scale <= link.cmd.scale;
						// untaken batch is dropped and reshifted.
						if (!take) begin
							gen_fresh <= gen_fresh || dac_batch_valid
								|| lfsr.advance || ramp.advance;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- verilog/dac_subsys_top.sv
`timescale 1ns/100ps

module dac_subsys_top #(
	parameter int batch_samples = dac_sample_pkg::default_batch_samples
) (
	input logic ps_clk,
	input logic ps_rst,
	input logic [dac_cfg_pkg::fresh_width-1:0] fresh_bits,
	input dac_sample_pkg::sample_t [batch_samples-1:0] seed_data,
	input dac_sample_pkg::sample_t ramp_start,
	input dac_sample_pkg::sample_t ramp_step,
	input logic [dac_sample_pkg::scale_width-1:0] scale_factor,
	input logic halt,
	input logic dac_rdy,
	output dac_sample_pkg::sample_t [batch_samples-1:0] dac_batch,
	output logic dac_batch_valid
);
	import dac_sample_pkg::*;

	// package types only cover the default lane count.
	if (batch_samples != default_batch_samples) begin : g_lane_check
		$error("dac_subsys_top: batch_samples must equal default_batch_samples");
	end

	cmd_link_if #(.batch_samples(batch_samples)) cmd_link ();
	gen_link_if #(.batch_samples(batch_samples)) lfsr_link ();
	gen_link_if #(.batch_samples(batch_samples)) ramp_link ();

	dac_config_ctrl #(.batch_samples(batch_samples)) u_ctrl (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.fresh_bits(fresh_bits),
		.seed_data(seed_data),
		.ramp_start(ramp_start),
		.ramp_step(ramp_step),
		.scale_factor(scale_factor),
		.halt(halt),
		.link(cmd_link.ctrl)
	);

	batch_mixer #(.batch_samples(batch_samples)) u_mixer (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.link(cmd_link.mixer),
		.lfsr(lfsr_link.mixer),
		.ramp(ramp_link.mixer),
		.dac_rdy(dac_rdy),
		.dac_batch(dac_batch),
		.dac_batch_valid(dac_batch_valid)
	);

	lfsr_batch_gen #(.batch_samples(batch_samples)) u_lfsr (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.gen(lfsr_link.gen)
	);

	ramp_batch_gen #(.batch_samples(batch_samples)) u_ramp (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.gen(ramp_link.gen)
	);

endmodule

//--- bench/dac_subsys_assert.sv
`timescale 1ns/100ps

module dac_subsys_assert #(
	parameter int batch_samples = dac_sample_pkg::default_batch_samples
) (
	input logic ps_clk,
	input logic ps_rst,
	input dac_sample_pkg::out_mode_t mode,
	input dac_sample_pkg::sample_t [batch_samples-1:0] dac_batch,
	input logic dac_batch_valid,
	input logic dac_rdy,
	input logic cmd_done
);
	import dac_sample_pkg::*;

	// output word frozen while the DAC stalls.
	batch_hold: assert property (@(posedge ps_clk) disable iff (ps_rst)
		dac_batch_valid && !dac_rdy |=> $stable(dac_batch))
		else $error("dac_batch changed under back-pressure");

	// only an applied command may drop a stalled batch.
	valid_hold: assert property (@(posedge ps_clk) disable iff (ps_rst)
		dac_batch_valid && !dac_rdy |=> dac_batch_valid || cmd_done)
		else $error("dac_batch_valid dropped under back-pressure");

	reset_low: assert property (@(posedge ps_clk)
		ps_rst |=> !dac_batch_valid)
		else $error("dac_batch_valid high after reset");

	idle_no_take: assert property (@(posedge ps_clk) disable iff (ps_rst)
		mode == mode_idle |-> !(dac_batch_valid && dac_rdy))
		else $error("batch taken in idle mode");

endmodule

bind batch_mixer dac_subsys_assert #(.batch_samples(batch_samples)) u_assert (
	.ps_clk(ps_clk),
	.ps_rst(ps_rst),
	.mode(mode),
	.dac_batch(dac_batch),
	.dac_batch_valid(dac_batch_valid),
	.dac_rdy(dac_rdy),
	.cmd_done(link.cmd_done)
);

//--- bench/dac_subsys_tb.sv
`timescale 1ns/100ps

module dac_subsys_tb;
	import dac_sample_pkg::*;
	import dac_cfg_pkg::*;

	localparam int batch_samples = default_batch_samples;
	localparam int wait_limit = 40;

	logic ps_clk;
	logic ps_rst;
	logic [fresh_width-1:0] fresh_bits;
	sample_t [batch_samples-1:0] seed_data;
	sample_t ramp_start;
	sample_t ramp_step;
	logic [scale_width-1:0] scale_factor;
	logic halt;
	logic dac_rdy;
	sample_t [batch_samples-1:0] dac_batch;
	logic dac_batch_valid;

	// model state, written by the stimulus only.
	out_mode_t mdl_mode;
	logic [scale_width-1:0] mdl_scale;
	sample_t [batch_samples-1:0] mdl_seeds;
	sample_t mdl_start;
	sample_t mdl_step;
	int mdl_base;

	int errors;
	int checks;
	// scoreboard side counters.
	int takes;
	int sb_errors;

	dac_subsys_top #(.batch_samples(batch_samples)) uut (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.fresh_bits(fresh_bits),
		.seed_data(seed_data),
		.ramp_start(ramp_start),
		.ramp_step(ramp_step),
		.scale_factor(scale_factor),
		.halt(halt),
		.dac_rdy(dac_rdy),
		.dac_batch(dac_batch),
		.dac_batch_valid(dac_batch_valid)
	);

	always #10 ps_clk = ~ps_clk;

	// galois lfsr, taps 0xb400, zero seed treated as 1.
	function automatic sample_t lfsr_ref(sample_t seed, int steps);
		sample_t s;
		s = (seed == '0) ? sample_t'(1) : seed;
		for (int k = 0; k < steps; k++) begin
			if (s[0]) begin
				s = (s >> 1) ^ 16'hB400;
			end else begin
				s = s >> 1;
			end
		end
		return s;
	endfunction

	function automatic sample_t ramp_ref(sample_t start, sample_t step, int lane, int n);
		int v;
		v = int'(start) + (lane + n * batch_samples) * int'(step);
		return sample_t'(v);
	endfunction

	function automatic void predict_batch(input int n,
		output sample_t [batch_samples-1:0] exp);
		for (int i = 0; i < batch_samples; i++) begin
			if (mdl_mode == mode_ramp) begin
				exp[i] = ramp_ref(mdl_start, mdl_step, i, n) >> mdl_scale;
			end else begin
				exp[i] = lfsr_ref(mdl_seeds[i], n) >> mdl_scale;
			end
		end
	endfunction

	function automatic int total_errors();
		return errors + sb_errors;
	endfunction

	task automatic check_batch(input sample_t [batch_samples-1:0] got,
		input sample_t [batch_samples-1:0] exp, input string what, inout int errs);
		for (int i = 0; i < batch_samples; i++) begin
			if (got[i] !== exp[i]) begin
				errs++;
				$display("mismatch at %0t: %s lane %0d got %h expected %h",
					$time, what, i, got[i], exp[i]);
			end
		end
	endtask

	task automatic check_valid(input logic exp, input string what);
		checks++;
		if (dac_batch_valid !== exp) begin
			errors++;
			$display("mismatch at %0t: %s valid %b expected %b",
				$time, what, dac_batch_valid, exp);
		end
	endtask

	// every take is checked against the model.
	always @(negedge ps_clk) begin : scoreboard
		sample_t [batch_samples-1:0] exp;
		if (ps_rst === 1'b0 && dac_batch_valid === 1'b1 && dac_rdy === 1'b1) begin
			if (mdl_mode == mode_idle) begin
				sb_errors++;
				$display("batch taken at %0t while no source was active", $time);
			end else begin
				predict_batch(takes - mdl_base, exp);
				check_batch(dac_batch, exp, "taken batch", sb_errors);
			end
			takes++;
		end
	end

	task automatic drive_edge();
		@(posedge ps_clk);
		#1;
	endtask

	task automatic wait_valid(input logic level, input string what);
		int cyc;
		cyc = 0;
		do begin
			@(negedge ps_clk);
			cyc++;
		end while (dac_batch_valid !== level && cyc < wait_limit);
		if (dac_batch_valid !== level) begin
			errors++;
			$display("timeout at %0t: valid never reached %b during %s", $time, level, what);
		end
	endtask

	// valid must drop, then rise with the new batch.
	task automatic wait_new_batch(input int lo, input int hi, input string what);
		int cyc;
		bit seen_low;
		bit done;
		cyc = 0;
		seen_low = 1'b0;
		done = 1'b0;
		while (!done && cyc < wait_limit) begin
			@(negedge ps_clk);
			cyc++;
			if (dac_batch_valid !== 1'b1) begin
				seen_low = 1'b1;
			end else if (seen_low) begin
				done = 1'b1;
			end
		end
		if (!done) begin
			errors++;
			$display("timeout at %0t: no new batch after the %s", $time, what);
		end else if (cyc - 1 < lo || cyc - 1 > hi) begin
			errors++;
			$display("the %s took %0d cycles to its first batch, expected %0d to %0d",
				what, cyc - 1, lo, hi);
		end
	endtask

	task automatic run_takes(input int n, input bit random_rdy, input string what);
		int cyc;
		int target;
		cyc = 0;
		target = takes + n;
		while (cyc < n * 12 + wait_limit) begin
			drive_edge();
			if (takes >= target) begin
				break;
			end
			dac_rdy = random_rdy ? ($urandom_range(1, 0) != 0) : 1'b1;
			cyc++;
		end
		dac_rdy = 1'b0;
		if (takes < target) begin
			errors++;
			$display("timeout at %0t: only %0d of %0d batches taken in %s",
				$time, n - (target - takes), n, what);
		end
	endtask

	task automatic load_seeds();
		dac_rdy = 1'b0;
		for (int i = 0; i < batch_samples; i++) begin
			seed_data[i] = sample_t'($urandom);
		end
		// lane 1 exercises the zero seed.
		seed_data[1] = '0;
		mdl_seeds = seed_data;
		mdl_mode = mode_lfsr;
		mdl_base = takes;
		fresh_bits[seed_valid_id] = 1'b1;
		drive_edge();
		fresh_bits[seed_valid_id] = 1'b0;
		wait_new_batch(3, 6, "seed command");
	endtask

	task automatic load_ramp();
		dac_rdy = 1'b0;
		ramp_start = sample_t'($urandom);
		ramp_step = sample_t'($urandom);
		mdl_start = ramp_start;
		mdl_step = ramp_step;
		mdl_mode = mode_ramp;
		mdl_base = takes;
		fresh_bits[ramp_valid_id] = 1'b1;
		drive_edge();
		fresh_bits[ramp_valid_id] = 1'b0;
		wait_new_batch(3, 6, "ramp command");
	endtask

	task automatic change_scale(input logic [scale_width-1:0] s);
		drive_edge();
		dac_rdy = 1'b0;
		wait_valid(1'b1, "scale setup");
		drive_edge();
		scale_factor = s;
		mdl_scale = s;
		wait_new_batch(1, 6, "scale change");
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		$display("test %0d %s finished with %0d errors", num, name, total_errors() - err_start);
	endtask

	initial begin
		int err_start;
		ps_clk = 1'b0;
		ps_rst = 1'b1;
		fresh_bits = '0;
		seed_data = '0;
		ramp_start = '0;
		ramp_step = '0;
		scale_factor = '0;
		halt = 1'b0;
		dac_rdy = 1'b0;
		mdl_mode = mode_idle;
		mdl_scale = '0;
		mdl_seeds = '0;
		mdl_start = '0;
		mdl_step = '0;
		mdl_base = 0;
		errors = 0;
		checks = 0;
		void'($urandom(99));
		repeat (3) @(posedge ps_clk);
		#1;
		ps_rst = 1'b0;

		err_start = total_errors();
		dac_rdy = 1'b1;
		repeat (20) begin
			@(negedge ps_clk);
			check_valid(1'b0, "after reset");
		end
		report_test(1, "reset idle", err_start);

		err_start = total_errors();
		drive_edge();
		load_seeds();
		run_takes(31, 1'b0, "lfsr run");
		report_test(2, "lfsr seeds", err_start);

		err_start = total_errors();
		drive_edge();
		load_ramp();
		run_takes(20, 1'b0, "ramp run");
		report_test(3, "ramp lanes", err_start);

		err_start = total_errors();
		run_takes(40, 1'b1, "random ready run");
		report_test(4, "random ready", err_start);

		err_start = total_errors();
		change_scale(4'd3);
		run_takes(20, 1'b1, "scaled run");
		change_scale(4'd0);
		run_takes(10, 1'b1, "unscaled run");
		report_test(5, "scale change", err_start);

		err_start = total_errors();
		drive_edge();
		dac_rdy = 1'b0;
		wait_valid(1'b1, "halt setup");
		drive_edge();
		halt = 1'b1;
		mdl_mode = mode_idle;
		drive_edge();
		halt = 1'b0;
		wait_valid(1'b0, "halt");
		drive_edge();
		dac_rdy = 1'b1;
		repeat (20) begin
			@(negedge ps_clk);
			check_valid(1'b0, "after halt");
		end
		drive_edge();
		load_seeds();
		run_takes(8, 1'b0, "restart run");
		report_test(6, "halt and restart", err_start);

		$display("checks %0d, batches %0d, errors %0d", checks, takes, total_errors());
		if (total_errors() == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- list.f
verilog/dac_sample_pkg.sv
verilog/dac_cfg_pkg.sv
verilog/cmd_link_if.sv
verilog/gen_link_if.sv
verilog/dac_config_ctrl.sv
verilog/lfsr_batch_gen.sv
verilog/ramp_batch_gen.sv
verilog/batch_mixer.sv
verilog/dac_subsys_top.sv
bench/dac_subsys_assert.sv
bench/dac_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dac_subsys_tb -f list.f -o dac_subsys_sim

out=$(./obj_dir/dac_subsys_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
